// File: src/fp_addsub_pkg.sv
package fp_addsub_pkg;

  localparam int EXP_W = 8;                          // Exponent field width
  localparam int MAN_W = 23;                         // Stored mantissa width
  localparam logic [EXP_W-1:0] EXP_MAX = 8'hff;      // Infinity or NaN exponent

  // One single precision word
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;
  } fp_word_t;

  typedef enum logic {
    op_add = 1'b0,
    op_sub = 1'b1
  } fp_op_e;

  // Exactly one bit set per operand
  typedef struct packed {
    logic zero;
    logic subnormal;
    logic normal;
    logic inf;
    logic nan;
  } operand_class_t;

  typedef enum logic [2:0] {
    st_idle,
    st_wait_input,
    st_decide,
    st_add,
    st_sub,
    st_normalize,
    st_done,
    st_hold
  } seq_state_e;

  typedef enum logic [2:0] {
    sel_zero,
    sel_a,
    sel_b,
    sel_neg_b,
    sel_arith,                                       // Working sign, exponent and mantissa
    sel_inf,
    sel_nan
  } result_sel_e;

  typedef struct packed {
    logic        load_ops;                           // Capture a, b and op
    logic        arith_sub;                          // Absolute difference instead of sum
    logic        arith_go;                           // Load working registers
    logic        shift_right;
    logic        shift_left;
    result_sel_e result_sel;
    logic        load_result;
  } dp_ctrl_t;

  typedef struct packed {
    operand_class_t cls_a;
    operand_class_t cls_b;
    logic           exp_equal;
    logic           eff_sub;                         // op ^ sign a ^ sign b
    logic           sub_op;                          // Captured op is a subtract
    logic           sum_bit24;                       // Sum needs a right shift
    logic           diff_zero;
    logic           diff_borrow;                     // Mantissa of B is larger
    logic           man_bit23;                       // Working mantissa is normalized
    logic           exp_is_one;
    logic           exp_overflow;
  } dp_status_t;

endpackage

// File: src/fp_sequencer.sv
module fp_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      iready,
  input  logic                      rtaken,
  input  fp_addsub_pkg::dp_status_t status,
  output fp_addsub_pkg::dp_ctrl_t   ctrl,
  output logic                      uready,
  output logic                      rready,
  output logic                      nan_out,
  output logic                      inf_out,
  output logic                      error_out
);

  fp_addsub_pkg::seq_state_e  state;
  fp_addsub_pkg::seq_state_e  state_next;
  fp_addsub_pkg::result_sel_e res_sel_q;
  fp_addsub_pkg::result_sel_e res_sel_d;
  fp_addsub_pkg::result_sel_e done_sel;

  logic capture;
  logic same_class;
  logic go_arith;
  logic nan_d;
  logic inf_d;
  logic err_d;
  logic overflow;

  assign capture    = (state == fp_addsub_pkg::st_wait_input) && iready;
  assign same_class = (status.cls_a.normal && status.cls_b.normal) ||
                      (status.cls_a.subnormal && status.cls_b.subnormal);

  // Result rules in priority order
  always_comb
  begin
    res_sel_d = fp_addsub_pkg::sel_zero;
    nan_d     = 1'b0;
    inf_d     = 1'b0;
    err_d     = 1'b0;
    go_arith  = 1'b0;
    if (status.cls_a.nan || status.cls_b.nan || (status.cls_a.inf && status.cls_b.inf))
    begin
      res_sel_d = fp_addsub_pkg::sel_nan;
      nan_d     = 1'b1;
    end
    else if (status.cls_a.inf || status.cls_b.inf)
    begin
      res_sel_d = fp_addsub_pkg::sel_inf;
      inf_d     = 1'b1;
    end
    else if (status.cls_a.zero && status.cls_b.zero)
      res_sel_d = fp_addsub_pkg::sel_zero;
    else if (status.cls_b.zero)
      res_sel_d = fp_addsub_pkg::sel_a;
    else if (status.cls_a.zero)
      res_sel_d = status.sub_op ? fp_addsub_pkg::sel_neg_b : fp_addsub_pkg::sel_b;
    else if (!same_class || !status.exp_equal)
      err_d = 1'b1;                                  // Alignment not supported
    else
    begin
      res_sel_d = fp_addsub_pkg::sel_arith;
      go_arith  = 1'b1;
    end
  end

  // Sum overflowed past the largest exponent
  assign overflow = (res_sel_q == fp_addsub_pkg::sel_arith) && status.exp_overflow;
  assign done_sel = overflow ? fp_addsub_pkg::sel_inf : res_sel_q;

  always_comb
  begin
    state_next = state;
    unique case (state)
      fp_addsub_pkg::st_idle:
        state_next = fp_addsub_pkg::st_wait_input;
      fp_addsub_pkg::st_wait_input:
        if (iready)
          state_next = fp_addsub_pkg::st_decide;
      fp_addsub_pkg::st_decide:
        if (!go_arith)
          state_next = fp_addsub_pkg::st_done;
        else if (status.eff_sub)
          state_next = fp_addsub_pkg::st_sub;
        else
          state_next = fp_addsub_pkg::st_add;
      fp_addsub_pkg::st_add:
        if (status.sum_bit24)
          state_next = fp_addsub_pkg::st_normalize;  // Normals carry into bit 24
        else
          state_next = fp_addsub_pkg::st_done;
      fp_addsub_pkg::st_sub:
        if (status.diff_zero || status.cls_a.subnormal)
          state_next = fp_addsub_pkg::st_done;
        else
          state_next = fp_addsub_pkg::st_normalize;
      fp_addsub_pkg::st_normalize:
        if (!status.eff_sub || status.man_bit23 || status.exp_is_one)
          state_next = fp_addsub_pkg::st_done;
      fp_addsub_pkg::st_done:
        state_next = fp_addsub_pkg::st_hold;
      fp_addsub_pkg::st_hold:
        if (rtaken)
          state_next = fp_addsub_pkg::st_idle;
      default:
        state_next = fp_addsub_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state <= fp_addsub_pkg::st_idle;
    else
      state <= state_next;
  end

  // Chosen source held until done
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      res_sel_q <= fp_addsub_pkg::sel_zero;
    else if (state == fp_addsub_pkg::st_decide)
      res_sel_q <= res_sel_d;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      nan_out   <= 1'b0;
      inf_out   <= 1'b0;
      error_out <= 1'b0;
    end
    else if (capture)
    begin
      nan_out   <= 1'b0;
      inf_out   <= 1'b0;
      error_out <= 1'b0;
    end
    else if (state == fp_addsub_pkg::st_decide)
    begin
      nan_out   <= nan_d;
      inf_out   <= inf_d;
      error_out <= err_d;
    end
    else if ((state == fp_addsub_pkg::st_done) && overflow)
      inf_out <= 1'b1;
  end

  always_comb
  begin
    ctrl            = '0;
    ctrl.result_sel = fp_addsub_pkg::sel_zero;
    unique case (state)
      fp_addsub_pkg::st_wait_input:
        ctrl.load_ops = iready;
      fp_addsub_pkg::st_add:
        ctrl.arith_go = 1'b1;
      fp_addsub_pkg::st_sub:
      begin
        ctrl.arith_go  = 1'b1;
        ctrl.arith_sub = 1'b1;
      end
      fp_addsub_pkg::st_normalize:
      begin
        ctrl.shift_right = !status.eff_sub;          // One step for a sum
        ctrl.shift_left  = status.eff_sub && !status.man_bit23 && !status.exp_is_one;
      end
      fp_addsub_pkg::st_done:
      begin
        ctrl.result_sel  = done_sel;
        ctrl.load_result = 1'b1;
      end
      default:
        ctrl = '0;
    endcase
  end

  assign uready = (state == fp_addsub_pkg::st_wait_input);
  assign rready = (state == fp_addsub_pkg::st_hold);

endmodule

// File: src/fp_datapath.sv
module fp_datapath (
  input  logic                       clk,
  input  logic                       reset,
  input  fp_addsub_pkg::fp_word_t    a,
  input  fp_addsub_pkg::fp_word_t    b,
  input  fp_addsub_pkg::fp_op_e      op,
  input  fp_addsub_pkg::dp_ctrl_t    ctrl,
  output fp_addsub_pkg::dp_status_t  status,
  output fp_addsub_pkg::fp_word_t    result
);

  localparam int WM_W = fp_addsub_pkg::MAN_W + 2;   // Carry, hidden bit and fraction

  fp_addsub_pkg::fp_word_t       a_q;
  fp_addsub_pkg::fp_word_t       b_q;
  fp_addsub_pkg::fp_op_e         op_q;
  fp_addsub_pkg::operand_class_t cls_a;
  fp_addsub_pkg::operand_class_t cls_b;
  fp_addsub_pkg::fp_word_t       res_d;

  logic [fp_addsub_pkg::MAN_W:0]   ma;
  logic [fp_addsub_pkg::MAN_W:0]   mb;
  logic [WM_W-1:0]                 raw_sum;
  logic [WM_W-1:0]                 raw_diff;
  logic [WM_W-1:0]                 abs_diff;
  logic                            borrow;
  logic                            diff_zero;
  logic [WM_W-1:0]                 wman_q;
  logic [fp_addsub_pkg::EXP_W-1:0] exp_q;
  logic                            sign_q;
  logic                            inf_sign;

  function automatic fp_addsub_pkg::operand_class_t classify(
    input fp_addsub_pkg::fp_word_t w
  );
    fp_addsub_pkg::operand_class_t c;
    logic exp_zero;
    logic exp_ones;
    logic man_zero;
    exp_zero    = (w.exp == '0);
    exp_ones    = (w.exp == fp_addsub_pkg::EXP_MAX);
    man_zero    = (w.man == '0);
    c.zero      = exp_zero && man_zero;
    c.subnormal = exp_zero && !man_zero;
    c.normal    = !exp_zero && !exp_ones;
    c.inf       = exp_ones && man_zero;
    c.nan       = exp_ones && !man_zero;
    return c;
  endfunction

  // Operands held for the whole operation
  always_ff @(posedge clk)
  begin
    if (ctrl.load_ops)
    begin
      a_q  <= a;
      b_q  <= b;
      op_q <= op;
    end
  end

  assign cls_a = classify(a_q);
  assign cls_b = classify(b_q);

  assign ma = {cls_a.normal, a_q.man};                // Hidden bit only for normals
  assign mb = {cls_b.normal, b_q.man};

  assign raw_sum   = {1'b0, ma} + {1'b0, mb};
  assign raw_diff  = {1'b0, ma} - {1'b0, mb};
  assign borrow    = raw_diff[WM_W-1];
  assign abs_diff  = borrow ? ({1'b0, mb} - {1'b0, ma}) : raw_diff;
  assign diff_zero = (ma == mb);

  // Working mantissa, exponent and sign
  always_ff @(posedge clk)
  begin
    if (ctrl.arith_go)
    begin
      if (ctrl.arith_sub)
      begin
        wman_q <= abs_diff;
        sign_q <= diff_zero ? 1'b0 : (a_q.sign ^ borrow);  // +0 on equal mantissas
        exp_q  <= (cls_a.normal && !diff_zero) ? a_q.exp : '0;
      end
      else
      begin
        wman_q <= raw_sum;
        sign_q <= a_q.sign;
        if (cls_a.normal)
          exp_q <= a_q.exp;
        else
          exp_q <= {{(fp_addsub_pkg::EXP_W-1){1'b0}}, raw_sum[fp_addsub_pkg::MAN_W]};
      end
    end
    else if (ctrl.shift_right)
    begin
      wman_q <= wman_q >> 1;
      exp_q  <= exp_q + 1;
    end
    else if (ctrl.shift_left)
    begin
      wman_q <= wman_q << 1;
      exp_q  <= exp_q - 1;
    end
  end

  // Infinity takes the sign of the infinite operand, else the working sign
  always_comb
  begin
    if (cls_a.inf)
      inf_sign = a_q.sign;
    else if (cls_b.inf)
      inf_sign = b_q.sign ^ (op_q == fp_addsub_pkg::op_sub);
    else
      inf_sign = sign_q;
  end

  always_comb
  begin
    res_d = '0;
    unique case (ctrl.result_sel)
      fp_addsub_pkg::sel_zero:
        res_d = '0;
      fp_addsub_pkg::sel_a:
        res_d = a_q;
      fp_addsub_pkg::sel_b:
        res_d = b_q;
      fp_addsub_pkg::sel_neg_b:
      begin
        res_d      = b_q;
        res_d.sign = ~b_q.sign;
      end
      fp_addsub_pkg::sel_arith:
      begin
        res_d.sign = sign_q;
        res_d.exp  = wman_q[fp_addsub_pkg::MAN_W] ? exp_q : '0;  // Stopped at 1 means subnormal
        res_d.man  = wman_q[fp_addsub_pkg::MAN_W-1:0];
      end
      fp_addsub_pkg::sel_inf:
      begin
        res_d.sign = inf_sign;
        res_d.exp  = fp_addsub_pkg::EXP_MAX;
      end
      fp_addsub_pkg::sel_nan:
      begin
        res_d.exp = fp_addsub_pkg::EXP_MAX;
        res_d.man = {1'b1, {(fp_addsub_pkg::MAN_W-1){1'b0}}};  // Quiet NaN
      end
      default:
        res_d = '0;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      result <= '0;
    else if (ctrl.load_result)
      result <= res_d;
  end

  assign status.cls_a        = cls_a;
  assign status.cls_b        = cls_b;
  assign status.exp_equal    = (a_q.exp == b_q.exp);
  assign status.eff_sub      = (op_q == fp_addsub_pkg::op_sub) ^ a_q.sign ^ b_q.sign;
  assign status.sub_op       = (op_q == fp_addsub_pkg::op_sub);
  assign status.sum_bit24    = raw_sum[WM_W-1];
  assign status.diff_zero    = diff_zero;
  assign status.diff_borrow  = borrow;
  assign status.man_bit23    = wman_q[fp_addsub_pkg::MAN_W];
  assign status.exp_is_one   = (exp_q == 1);
  assign status.exp_overflow = (exp_q == fp_addsub_pkg::EXP_MAX);

endmodule

// File: src/fp_addsub.sv
module fp_addsub (
  input  logic                    clk,
  input  logic                    reset,
  input  fp_addsub_pkg::fp_word_t a,
  input  fp_addsub_pkg::fp_word_t b,
  input  fp_addsub_pkg::fp_op_e   op,
  input  logic                    iready,
  input  logic                    rtaken,
  output fp_addsub_pkg::fp_word_t result,
  output logic                    uready,
  output logic                    rready,
  output logic                    nan_out,
  output logic                    inf_out,
  output logic                    error_out
);

  fp_addsub_pkg::dp_ctrl_t   ctrl;                   // Sequencer to datapath
  fp_addsub_pkg::dp_status_t status;                 // Datapath to sequencer

  fp_sequencer i_fp_sequencer (
    .clk       (clk),
    .reset     (reset),
    .iready    (iready),
    .rtaken    (rtaken),
    .status    (status),
    .ctrl      (ctrl),
    .uready    (uready),
    .rready    (rready),
    .nan_out   (nan_out),
    .inf_out   (inf_out),
    .error_out (error_out)
  );

  fp_datapath i_fp_datapath (
    .clk    (clk),
    .reset  (reset),
    .a      (a),
    .b      (b),
    .op     (op),
    .ctrl   (ctrl),
    .status (status),
    .result (result)
  );

endmodule

// File: tests/fp_addsub_checker.sv
module fp_addsub_checker (
  input  logic                    clk,
  input  logic                    reset,
  input  fp_addsub_pkg::fp_word_t result,
  input  logic                    uready,
  input  logic                    rready,
  input  logic                    nan_out,
  input  logic                    inf_out,
  input  logic                    error_out,
  input  int                      test_id,
  input  fp_addsub_pkg::fp_word_t exp_result,
  input  logic [2:0]              exp_flags,       // NaN, infinity, error
  output int                      tests_done,
  output int                      tests_failed,
  output int                      errors
);

  fp_addsub_pkg::fp_word_t held_result;
  logic [2:0]              held_flags;
  logic [2:0]              flags;
  logic                    active = 1'b0;           // rready seen for this test
  logic                    test_bad = 1'b0;
  logic                    moved = 1'b0;
  logic                    reset_reported = 1'b0;
  int                      n_done = 0;
  int                      n_failed = 0;
  int                      n_errors = 0;

  assign flags        = {nan_out, inf_out, error_out};
  assign tests_done   = n_done;
  assign tests_failed = n_failed;
  assign errors       = n_errors;

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("mismatch at time %0t: %s expected 'h%08h, got 'h%08h",
               $time, name, expected, actual);
      n_errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (expected !== actual)
    begin
      $display("mismatch at time %0t: %s expected %b, got %b", $time, name, expected, actual);
      n_errors++;
      test_bad = 1'b1;
    end
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change
  always @(negedge clk)
  begin
    if (reset)
    begin
      if (!reset_reported && (uready || rready || flags != 3'b000 || result != '0))
      begin
        $display("error at time %0t: outputs are not cleared while reset is high", $time);
        n_errors++;
        reset_reported = 1'b1;
      end
    end
    else if (rready && !active)
    begin
      active   = 1'b1;
      test_bad = 1'b0;
      moved    = 1'b0;
      compare_word("result", exp_result, result);
      compare_bit("nan_out", exp_flags[2], nan_out);
      compare_bit("inf_out", exp_flags[1], inf_out);
      compare_bit("error_out", exp_flags[0], error_out);
      held_result = result;
      held_flags  = flags;
    end
    else if (rready)
    begin
      if (!moved && (result !== held_result || flags !== held_flags || uready))
      begin
        $display("error at time %0t: result or flags changed while rready was high", $time);
        n_errors++;
        test_bad = 1'b1;
        moved    = 1'b1;
      end
    end
    else if (active)
    begin
      active = 1'b0;                                // rtaken took the result
      n_done++;
      if (test_bad)
      begin
        n_failed++;
        $display("test %0d: FAILED", test_id);
      end
      else
        $display("test %0d: ok, result 'h%08h flags %b", test_id, held_result, held_flags);
    end
  end

endmodule

// File: tests/fp_addsub_tb.sv
module fp_addsub_tb;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        op;                                // 1 for subtract
    logic [31:0] res;
    logic [2:0]  flags;                             // NaN, infinity, error
  } vector_t;

  localparam int N_VEC = 26;
  localparam int LIMIT = 100;                       // Cycles allowed per wait

  logic                    clk;
  logic                    reset;
  fp_addsub_pkg::fp_word_t a;
  fp_addsub_pkg::fp_word_t b;
  fp_addsub_pkg::fp_op_e   op;
  logic                    iready;
  logic                    rtaken;
  fp_addsub_pkg::fp_word_t result;
  logic                    uready;
  logic                    rready;
  logic                    nan_out;
  logic                    inf_out;
  logic                    error_out;

  vector_t                 vec [N_VEC];
  int                      cur_test;
  fp_addsub_pkg::fp_word_t exp_result;
  logic [2:0]              exp_flags;
  int                      tests_done;
  int                      tests_failed;
  int                      errors;
  int                      pause;
  logic                    timed_out;

  always #5 clk = ~clk;

  fp_addsub i_fp_addsub (
    .clk       (clk),
    .reset     (reset),
    .a         (a),
    .b         (b),
    .op        (op),
    .iready    (iready),
    .rtaken    (rtaken),
    .result    (result),
    .uready    (uready),
    .rready    (rready),
    .nan_out   (nan_out),
    .inf_out   (inf_out),
    .error_out (error_out)
  );

  fp_addsub_checker i_checker (
    .clk          (clk),
    .reset        (reset),
    .result       (result),
    .uready       (uready),
    .rready       (rready),
    .nan_out      (nan_out),
    .inf_out      (inf_out),
    .error_out    (error_out),
    .test_id      (cur_test),
    .exp_result   (exp_result),
    .exp_flags    (exp_flags),
    .tests_done   (tests_done),
    .tests_failed (tests_failed),
    .errors       (errors)
  );

  task automatic load_vectors;
    vec[0]  = '{32'h7fc00000, 32'h3f800000, 1'b0, 32'h7fc00000, 3'b100};  // NaN a
    vec[1]  = '{32'h3f800000, 32'h7f800001, 1'b1, 32'h7fc00000, 3'b100};  // NaN b
    vec[2]  = '{32'hff800000, 32'h3f800000, 1'b0, 32'hff800000, 3'b010};  // Infinite a
    vec[3]  = '{32'h3f800000, 32'h7f800000, 1'b1, 32'hff800000, 3'b010};  // Infinite b, sub
    vec[4]  = '{32'hbf800000, 32'hff800000, 1'b0, 32'hff800000, 3'b010};
    vec[5]  = '{32'h7f800000, 32'hff800000, 1'b0, 32'h7fc00000, 3'b100};  // Both infinite
    vec[6]  = '{32'h80000000, 32'h00000000, 1'b0, 32'h00000000, 3'b000};  // Both zero
    vec[7]  = '{32'hc0490fdb, 32'h80000000, 1'b1, 32'hc0490fdb, 3'b000};  // B zero
    vec[8]  = '{32'h00000000, 32'h40490fdb, 1'b0, 32'h40490fdb, 3'b000};  // A zero
    vec[9]  = '{32'h00000000, 32'h40490fdb, 1'b1, 32'hc0490fdb, 3'b000};
    vec[10] = '{32'h3f800000, 32'h3fc00000, 1'b0, 32'h40200000, 3'b000};  // 1.0 + 1.5
    vec[11] = '{32'h3f800000, 32'hbfc00000, 1'b1, 32'h40200000, 3'b000};  // 1.0 - -1.5
    vec[12] = '{32'h00000001, 32'h00000002, 1'b0, 32'h00000003, 3'b000};
    vec[13] = '{32'h00400000, 32'h00400000, 1'b0, 32'h00800000, 3'b000};  // Carry to exp 1
    vec[14] = '{32'h7f000000, 32'h7f000000, 1'b0, 32'h7f800000, 3'b010};  // Overflow
    vec[15] = '{32'hff400000, 32'hff000000, 1'b0, 32'hff800000, 3'b010};
    vec[16] = '{32'h3fc00000, 32'h3fb00000, 1'b1, 32'h3e000000, 3'b000};  // Three shifts
    vec[17] = '{32'h3f800000, 32'h3fe00000, 1'b1, 32'hbf400000, 3'b000};  // Negative
    vec[18] = '{32'hbf800000, 32'hbfc00000, 1'b1, 32'h3f000000, 3'b000};
    vec[19] = '{32'h01000001, 32'h01000000, 1'b1, 32'h00000002, 3'b000};  // Stops at exp 1
    vec[20] = '{32'h01000001, 32'h81000000, 1'b0, 32'h00000002, 3'b000};
    vec[21] = '{32'h40490fdb, 32'h40490fdb, 1'b1, 32'h00000000, 3'b000};  // Equal operands
    vec[22] = '{32'h00000001, 32'h00000003, 1'b1, 32'h80000002, 3'b000};
    vec[23] = '{32'h3f800000, 32'h40000000, 1'b0, 32'h00000000, 3'b001};  // Unequal exps
    vec[24] = '{32'h3f800000, 32'h00000001, 1'b0, 32'h00000000, 3'b001};  // Mixed classes
    vec[25] = '{32'h00400000, 32'hc0000000, 1'b1, 32'h00000000, 3'b001};
  endtask

  task automatic wait_uready;
    int cycles;
    cycles = 0;
    while (!uready && cycles < LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!uready)
    begin
      $display("timeout: uready stayed low for %0d cycles before test %0d", LIMIT, cur_test);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_rready;
    int cycles;
    cycles = 0;
    while (!rready && cycles < LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!rready)
    begin
      $display("timeout: rready stayed low for %0d cycles in test %0d", LIMIT, cur_test);
      timed_out = 1'b1;
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    reset      = 1'b1;
    a          = '0;
    b          = '0;
    op         = fp_addsub_pkg::op_add;
    iready     = 1'b0;
    rtaken     = 1'b0;
    cur_test   = 0;
    exp_result = '0;
    exp_flags  = 3'b000;
    timed_out  = 1'b0;
    void'($urandom(32'hd8b4_e3b7));
    load_vectors();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < N_VEC && !timed_out; i++)
    begin
      wait_uready();
      if (!timed_out)
      begin
        pause = $urandom_range(3, 0);
        repeat (pause) @(negedge clk);               // uready must stay high meanwhile
        cur_test   = i;
        exp_result = vec[i].res;
        exp_flags  = vec[i].flags;
        a          = vec[i].a;
        b          = vec[i].b;
        op         = fp_addsub_pkg::fp_op_e'(vec[i].op);
        iready     = 1'b1;
        @(negedge clk);
        iready = 1'b0;
        a      = $urandom();                         // Operands must already be held
        b      = $urandom();
        wait_rready();
      end
      if (!timed_out)
      begin
        pause = $urandom_range(3, 0);
        repeat (pause) @(negedge clk);
        rtaken = 1'b1;
        @(negedge clk);
        rtaken = 1'b0;
      end
    end

    repeat (2) @(negedge clk);
    $display("tests run %0d, failed %0d, errors %0d, timed out %0d",
             tests_done, tests_failed, errors, timed_out);
    if (!timed_out && errors == 0 && tests_failed == 0 && tests_done == N_VEC)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: flist.f
src/fp_addsub_pkg.sv
src/fp_sequencer.sv
src/fp_datapath.sv
src/fp_addsub.sv
tests/fp_addsub_checker.sv
tests/fp_addsub_tb.sv

// File: Makefile
# Verilator build and run of the floating-point add/subtract testbench

VERILATOR ?= verilator
TOP       ?= fp_addsub_tb
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
	  echo "Result: FAIL"; exit 1; \
	elif ! grep -q "sim passed" $(LOG); then \
	  echo "Result: FAIL, no verdict in $(LOG)"; exit 1; \
	else \
	  echo "Result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
